// File: hw/bus_pkg.sv
package bus_pkg;

   // bus widths
   localparam int addr_w = 32;
   localparam int data_w = 32;
   localparam int strb_w = data_w / 8;
   localparam int id_w   = 4;

   typedef enum logic [0:0]
   {
      op_read  = 1'b0,
      op_write = 1'b1
   } op_e;

   // one request per strobe, 73 bits
   typedef struct packed
   {
      op_e               op;
      logic [id_w-1:0]   id;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] wdata;
      logic [strb_w-1:0] wstrb;
   } bus_req_t;

   // one response per request, 38 bits
   typedef struct packed
   {
      op_e               op;
      logic [id_w-1:0]   id;
      logic              err;
      logic [data_w-1:0] rdata;
   } bus_rsp_t;

endpackage

// File: hw/map_pkg.sv
package map_pkg;

   import bus_pkg::*;

   // encoding doubles as the sel bit index
   typedef enum logic [1:0]
   {
      tgt_ram  = 2'd0,
      tgt_vga  = 2'd1,
      tgt_peri = 2'd2,
      tgt_none = 2'd3
   } target_e;

   // default window map
   localparam logic [addr_w-1:0] ram_base_d  = 32'h1c00_0000;
   localparam logic [addr_w-1:0] vga_base_d  = 32'h0001_0000;
   localparam logic [addr_w-1:0] peri_base_d = 32'h0002_0000;

   localparam int ram_bits_d  = 16;
   localparam int vga_bits_d  = 11;
   localparam int peri_bits_d = 16;

   // word offset wide enough for the largest window
   localparam int off_w = 14;

   typedef struct packed
   {
      bus_req_t         req;
      target_e          tgt;
      logic [off_w-1:0] offset;
   } dec_req_t;

endpackage

// File: hw/addr_decode.sv
`timescale 1ns/10ps

module addr_decode
   import bus_pkg::*;
   import map_pkg::*;
#(
   parameter logic [addr_w-1:0] ram_base  = ram_base_d,
   parameter logic [addr_w-1:0] vga_base  = vga_base_d,
   parameter logic [addr_w-1:0] peri_base = peri_base_d,
   parameter int                ram_bits  = ram_bits_d,
   parameter int                vga_bits  = vga_bits_d,
   parameter int                peri_bits = peri_bits_d
)
(
   input  logic     clk,
   input  logic     resetn,
   input  logic     req_valid,
   input  bus_req_t req,
   output logic     dec_valid,
   output dec_req_t dec,
   output logic [2:0] sel
);

   logic              ram_hit;
   logic              vga_hit;
   logic              peri_hit;
   target_e           tgt_d;
   int                win_bits;
   logic [addr_w-1:0] off_full;
   logic [2:0]        sel_d;

   assign ram_hit  = (req.addr >> ram_bits) == (ram_base >> ram_bits);
   assign vga_hit  = (req.addr >> vga_bits) == (vga_base >> vga_bits);
   assign peri_hit = (req.addr >> peri_bits) == (peri_base >> peri_bits);

   // overlapping windows resolve in ram, vga, peri order
   always_comb
   begin
      tgt_d    = tgt_none;
      win_bits = 2;
      if (ram_hit)
      begin
         tgt_d    = tgt_ram;
         win_bits = ram_bits;
      end
      else if (vga_hit)
      begin
         tgt_d    = tgt_vga;
         win_bits = vga_bits;
      end
      else if (peri_hit)
      begin
         tgt_d    = tgt_peri;
         win_bits = peri_bits;
      end
   end

   // byte address inside the window, then drop the byte bits
   assign off_full = (req.addr & ((32'd1 << win_bits) - 32'd1)) >> 2;
   assign sel_d    = (tgt_d == tgt_none) ? 3'b000 : (3'b001 << tgt_d);

   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         dec_valid <= 1'b0;
         sel       <= 3'b000;
      end
      else
      begin
         dec_valid <= req_valid;
         sel       <= req_valid ? sel_d : 3'b000;
      end
   end

   always_ff @(posedge clk)
   begin
      if (req_valid)
      begin
         dec.req    <= req;
         dec.tgt    <= tgt_d;
         dec.offset <= off_full[off_w-1:0];
      end
   end

   // select agrees with the target handed to the merge stage
   a_sel_onehot: assert property (@(posedge clk) disable iff (!resetn)
      dec_valid |-> $onehot0(sel) && ((sel == 3'b000) == (dec.tgt == tgt_none)));

endmodule

// File: hw/target_sram.sv
`timescale 1ns/10ps

module target_sram
   import bus_pkg::*;
   import map_pkg::*;
#(
   parameter int addr_bits = 16
)
(
   input  logic              clk,
   input  logic              sel,
   input  logic              dec_valid,
   input  dec_req_t          dec,
   output logic [data_w-1:0] rdata
);

   localparam int idx_w = addr_bits - 2;
   localparam int depth = 2 ** idx_w;

   logic [data_w-1:0] mem [depth];
   logic [idx_w-1:0]  idx;
   logic              wr_en;
   logic              rd_en;

   // only the low offset bits address this window
   assign idx   = dec.offset[idx_w-1:0];
   assign wr_en = dec_valid && sel && (dec.req.op == op_write);
   assign rd_en = dec_valid && sel && (dec.req.op == op_read);

   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         for (int b = 0; b < strb_w; b++)
         begin
            if (dec.req.wstrb[b])
            begin
               mem[idx][8*b +: 8] <= dec.req.wdata[8*b +: 8];
            end
         end
      end
   end

   // old word on a same-cycle read and write
   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         rdata <= mem[idx];
      end
   end

   // a write that touches no lane would still be acknowledged
   a_wstrb_set: assert property (@(posedge clk)
      wr_en |-> dec.req.wstrb != '0);

endmodule

// File: hw/response_merge.sv
`timescale 1ns/10ps

module response_merge
   import bus_pkg::*;
   import map_pkg::*;
(
   input  logic              clk,
   input  logic              resetn,
   input  logic              dec_valid,
   input  dec_req_t          dec,
   input  logic [data_w-1:0] ram_rdata,
   input  logic [data_w-1:0] vga_rdata,
   input  logic [data_w-1:0] peri_rdata,
   output logic              rsp_valid,
   output bus_rsp_t          rsp
);

   logic              valid_q;
   dec_req_t          dec_q;
   logic [data_w-1:0] win_rdata;

   // copy of the request in step with the window read
   always_ff @(posedge clk)
   begin
      if (!resetn)
      begin
         valid_q   <= 1'b0;
         rsp_valid <= 1'b0;
      end
      else
      begin
         valid_q   <= dec_valid;
         rsp_valid <= valid_q;
      end
   end

   always_ff @(posedge clk)
   begin
      if (dec_valid)
      begin
         dec_q <= dec;
      end
   end

   always_comb
   begin
      case (dec_q.tgt)
         tgt_ram:  win_rdata = ram_rdata;
         tgt_vga:  win_rdata = vga_rdata;
         tgt_peri: win_rdata = peri_rdata;
         default:  win_rdata = '0;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (valid_q)
      begin
         rsp.op    <= dec_q.req.op;
         rsp.id    <= dec_q.req.id;
         rsp.err   <= (dec_q.tgt == tgt_none);
         rsp.rdata <= (dec_q.req.op == op_read) ? win_rdata : '0;
      end
   end

   // an error response carries no data
   a_err_nodata: assert property (@(posedge clk) disable iff (!resetn)
      rsp_valid && rsp.err |-> rsp.rdata == '0);

endmodule

// File: hw/soc_fabric.sv
`timescale 1ns/10ps

module soc_fabric
   import bus_pkg::*;
   import map_pkg::*;
#(
   parameter logic [addr_w-1:0] ram_base  = ram_base_d,
   parameter logic [addr_w-1:0] vga_base  = vga_base_d,
   parameter logic [addr_w-1:0] peri_base = peri_base_d,
   parameter int                ram_bits  = ram_bits_d,
   parameter int                vga_bits  = vga_bits_d,
   parameter int                peri_bits = peri_bits_d
)
(
   input  logic     clk,
   input  logic     resetn,
   input  logic     req_valid,
   input  bus_req_t req,
   output logic     rsp_valid,
   output bus_rsp_t rsp
);

   logic              dec_valid;
   dec_req_t          dec;
   logic [2:0]        sel;
   logic [data_w-1:0] ram_rdata;
   logic [data_w-1:0] vga_rdata;
   logic [data_w-1:0] peri_rdata;

   addr_decode #(
      .ram_base  (ram_base  ),
      .vga_base  (vga_base  ),
      .peri_base (peri_base ),
      .ram_bits  (ram_bits  ),
      .vga_bits  (vga_bits  ),
      .peri_bits (peri_bits )
   ) u_decode (
      .clk       (clk       ),
      .resetn    (resetn    ),
      .req_valid (req_valid ),
      .req       (req       ),
      .dec_valid (dec_valid ),
      .dec       (dec       ),
      .sel       (sel       )
   );

   // sel bits follow the target encoding
   target_sram #(.addr_bits(ram_bits)) u_ram (
      .clk       (clk          ),
      .sel       (sel[tgt_ram] ),
      .dec_valid (dec_valid    ),
      .dec       (dec          ),
      .rdata     (ram_rdata    )
   );

   target_sram #(.addr_bits(vga_bits)) u_vga (
      .clk       (clk          ),
      .sel       (sel[tgt_vga] ),
      .dec_valid (dec_valid    ),
      .dec       (dec          ),
      .rdata     (vga_rdata    )
   );

   target_sram #(.addr_bits(peri_bits)) u_peri (
      .clk       (clk           ),
      .sel       (sel[tgt_peri] ),
      .dec_valid (dec_valid     ),
      .dec       (dec           ),
      .rdata     (peri_rdata    )
   );

   response_merge u_merge (
      .clk        (clk        ),
      .resetn     (resetn     ),
      .dec_valid  (dec_valid  ),
      .dec        (dec        ),
      .ram_rdata  (ram_rdata  ),
      .vga_rdata  (vga_rdata  ),
      .peri_rdata (peri_rdata ),
      .rsp_valid  (rsp_valid  ),
      .rsp        (rsp        )
   );

endmodule

// File: bench/tb_soc_fabric.sv
`timescale 1ns/10ps

module tb_soc_fabric
   import bus_pkg::*;
();

   typedef struct packed
   {
      bus_rsp_t    rsp;
      logic [31:0] cyc;
   } expect_t;

   logic        clk = 1'b0;
   logic        resetn;
   logic        req_valid;
   bus_req_t    req;
   logic        rsp_valid;
   bus_rsp_t    rsp;
   logic [31:0] cycle = '0;

   bus_req_t trace_req[$];
   bus_rsp_t trace_rsp[$];
   expect_t  exp_q[$];
   expect_t  head;

   soc_fabric DUT (
      .clk       (clk       ),
      .resetn    (resetn    ),
      .req_valid (req_valid ),
      .req       (req       ),
      .rsp_valid (rsp_valid ),
      .rsp       (rsp       )
   );

   always #4 clk = ~clk;

   always @(posedge clk)
   begin
      cycle <= cycle + 32'd1;
   end

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
      begin
         abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic load_trace();
      int          fd;
      int          n;
      string       line;
      logic [31:0] f_op, f_id, f_addr, f_wdata, f_wstrb, f_rdata, f_err;
      bus_req_t    r;
      bus_rsp_t    e;
      fd = $fopen("bench/fabric_trace.txt", "r");
      if (fd == 0)
      begin
         abort_run("could not open bench/fabric_trace.txt");
      end
      while (!$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line.getc(0) == "#")
         begin
            continue;
         end
         n = $sscanf(line, "%h %h %h %h %h %h %h",
                     f_op, f_id, f_addr, f_wdata, f_wstrb, f_rdata, f_err);
         if (n != 7)
         begin
            abort_run($sformatf("malformed trace line: %s", line));
         end
         r.op    = op_e'(f_op[0]);
         r.id    = f_id[id_w-1:0];
         r.addr  = f_addr;
         r.wdata = f_wdata;
         r.wstrb = f_wstrb[strb_w-1:0];
         e.op    = op_e'(f_op[0]);
         e.id    = f_id[id_w-1:0];
         e.err   = f_err[0];
         e.rdata = f_rdata;
         trace_req.push_back(r);
         trace_rsp.push_back(e);
      end
      $fclose(fd);
   endtask

   // responses seen half a cycle after the edge that raised them
   always @(negedge clk)
   begin
      if (rsp_valid !== 1'b0 && rsp_valid !== 1'b1)
      begin
         abort_run("rsp_valid is unknown");
      end
      else if (rsp_valid)
      begin
         if (exp_q.size() == 0)
         begin
            abort_run("response arrived with no request outstanding");
         end
         else
         begin
            head = exp_q.pop_front();
            if (cycle != head.cyc + 32'd3)
            begin
               abort_run($sformatf("response id %0d came at cycle %0d instead of %0d",
                                   rsp.id, cycle, head.cyc + 32'd3));
            end
            check_equal("rsp.id", rsp.id, head.rsp.id);
            check_equal("rsp.op", rsp.op, head.rsp.op);
            check_equal("rsp.err", rsp.err, head.rsp.err);
            check_equal("rsp.rdata", rsp.rdata, head.rsp.rdata);
         end
      end
   end

   initial
   begin
      expect_t     e;
      logic [31:0] rng;
      int          gap;
      resetn    = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      rng       = 32'hb96914e3;
      load_trace();
      if (trace_req.size() == 0)
      begin
         abort_run("trace holds no requests");
      end
      fork
         begin
            repeat (trace_req.size() * 4 + 50) @(posedge clk);
            abort_run("watchdog expired before all responses arrived");
         end
      join_none
      repeat (4) @(posedge clk);
      resetn <= 1'b1;
      // a few quiet cycles so a stray response would show up
      repeat (3) @(posedge clk);
      for (int i = 0; i < trace_req.size(); i++)
      begin
         @(posedge clk);
         req_valid <= 1'b1;
         req       <= trace_req[i];
         // edge number that puts this request on the bus
         e.rsp = trace_rsp[i];
         e.cyc = cycle + 32'd1;
         exp_q.push_back(e);
         rng = xorshift32(rng);
         gap = rng % 3;
         repeat (gap)
         begin
            @(posedge clk);
            req_valid <= 1'b0;
         end
      end
      @(posedge clk);
      req_valid <= 1'b0;
      while (exp_q.size() != 0)
      begin
         @(posedge clk);
      end
      repeat (5) @(posedge clk);
      $display("TEST OK");
      $finish;
   end

endmodule

// File: bench/fabric_trace.txt
# columns: op id addr wdata wstrb exp_rdata exp_err, all hex
# op 1 is a write, op 0 a read; writes and errors expect rdata 0
1 1 1c000010 11223344 f 00000000 0
1 2 00010010 55667788 f 00000000 0
1 3 00020010 99aabbcc f 00000000 0
0 4 1c000010 00000000 0 11223344 0
0 5 00010010 00000000 0 55667788 0
0 6 00020010 00000000 0 99aabbcc 0
1 7 1c000010 deadbeef f 00000000 0
0 8 00010010 00000000 0 55667788 0
0 9 00020010 00000000 0 99aabbcc 0
0 a 1c000010 00000000 0 deadbeef 0
1 b 1c00fffc 01020304 f 00000000 0
1 c 1c00fffc aabbccdd 5 00000000 0
0 d 1c00fffc 00000000 0 01bb03dd 0
1 e 000107fc cafef00d f 00000000 0
1 f 000107fc 12345678 8 00000000 0
0 0 000107fc 00000000 0 12fef00d 0
1 1 0002abc8 ffffffff f 00000000 0
1 2 0002abc8 00000000 6 00000000 0
0 3 0002abc8 00000000 0 ff0000ff 0
0 4 00040000 00000000 0 00000000 1
1 5 00040000 12345678 f 00000000 1
0 6 00010800 00000000 0 00000000 1
0 7 1c010000 00000000 0 00000000 1
1 8 1c000100 0badf00d f 00000000 0
0 9 1c000100 00000000 0 0badf00d 0
1 a 00010104 13579bdf f 00000000 0
0 b 00010104 00000000 0 13579bdf 0
1 c 00020104 2468ace0 f 00000000 0
0 d 00020104 00000000 0 2468ace0 0
1 e 1c000100 feedface f 00000000 0
0 f 1c000100 00000000 0 feedface 0
0 0 1c000010 00000000 0 deadbeef 0
0 1 0002abc8 00000000 0 ff0000ff 0
0 2 00010010 00000000 0 55667788 0

// File: all.f
hw/bus_pkg.sv
hw/map_pkg.sv
hw/addr_decode.sv
hw/target_sram.sv
hw/response_merge.sv
hw/soc_fabric.sv
bench/tb_soc_fabric.sv
